//--- compile.f
logic/access_pkg.sv
logic/mem_map_pkg.sv
logic/key_irq.sv
logic/onchip_ram.sv
logic/sdram_bridge.sv
logic/bus_sequencer.sv
logic/soc_top.sv
test/sdram_model.sv
test/tb_soc.sv

//--- test/tb_soc.sv
`timescale 1ns/1ps

module tb_soc;
    import access_pkg::*;
    import mem_map_pkg::*;

    localparam int TIMEOUT = 200;  // cycles allowed per wait

    logic                    CLOCK_50 = 1'b0;
    logic                    KEY0;
    logic [ADDR_W-1:0]       bus_address;
    logic [DATA_W-1:0]       bus_write_data;
    ls_type_t                bus_ls_type;
    logic                    bus_read_enable;
    logic                    bus_write_enable;
    logic [DATA_W-1:0]       bus_read_data;
    logic                    bus_read_done;
    logic                    bus_write_done;
    logic [SDRAM_ADDR_W-1:0] sdram_addr;
    logic [SDRAM_DATA_W-1:0] sdram_wrdata;
    logic [1:0]              sdram_byte_en;
    logic                    sdram_read_en;
    logic                    sdram_write_en;
    logic [SDRAM_DATA_W-1:0] sdram_rddata;
    logic                    sdram_req_wait;
    logic                    key_strobe;
    logic [7:0]              key_code;
    logic                    key_irq;
    logic                    irq_ack;

    logic [7:0] ref_mem [logic [63:0]];  // byte image of what was stored
    int         data_errs;
    int         proto_errs;
    int         timeouts;

    soc_top DUT (.*);
    sdram_model sdram_mem (.*);

    initial begin
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0) bus_read_enable |=> !bus_read_done)
        else begin
            proto_errs++;
            $display("bus_read_done did not fall the cycle after bus_read_enable");
        end
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) bus_write_enable |=> !bus_write_done)
        else begin
            proto_errs++;
            $display("bus_write_done did not fall the cycle after bus_write_enable");
        end
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(key_strobe) && key_code != 8'd0 |=> key_irq)
        else begin
            proto_errs++;
            $display("FAILED key_irq: expected %h, got %h", 1'b1, $sampled(key_irq));
        end
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_ack && !($rose(key_strobe) && key_code != 8'd0) |=> !key_irq)
        else begin
            proto_errs++;
            $display("FAILED key_irq: expected %h, got %h", 1'b0, $sampled(key_irq));
        end
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $rose(key_strobe) && key_code == 8'd0 && !key_irq |=> !key_irq)
        else begin
            proto_errs++;
            $display("key_irq rose on a strobe with a zero key code");
        end

    // little-endian gather, then extend by the type code
    function automatic logic [63:0] predict_load(input logic [63:0] addr, input logic [2:0] code);
        int          nbytes;
        int          i;
        logic [63:0] v;
        logic        neg;
        nbytes = 1 << code[1:0];
        v = '0;
        for (i = 0; i < nbytes; i++)
            v[8*i +: 8] = ref_mem[addr + 64'(i)];
        neg = !code[2] && v[8*nbytes-1];
        for (i = 8 * nbytes; i < 64; i++)
            v[i] = neg;
        return v;
    endfunction

    task automatic bus_store(input logic [63:0] addr, input logic [2:0] code,
                             input logic [63:0] data);
        int n;
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_ls_type.code = code;
        bus_write_data   = data;
        bus_write_enable = 1'b1;
        @(negedge CLOCK_50);
        bus_write_enable = 1'b0;
        n = 0;
        while (!bus_write_done && n < TIMEOUT) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (!bus_write_done) begin
            timeouts++;
            $display("store to %h never finished", addr);
        end
        for (int i = 0; i < (1 << code[1:0]); i++)
            ref_mem[addr + 64'(i)] = data[8*i +: 8];
    endtask

    task automatic bus_load(input logic [63:0] addr, input logic [2:0] code,
                            input logic [63:0] expected);
        int n;
        @(negedge CLOCK_50);
        bus_address      = addr;
        bus_ls_type.code = code;
        bus_read_enable  = 1'b1;
        @(negedge CLOCK_50);
        bus_read_enable = 1'b0;
        n = 0;
        while (!bus_read_done && n < TIMEOUT) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (!bus_read_done) begin
            timeouts++;
            $display("load from %h never finished", addr);
        end else begin
            assert (bus_read_data === expected)
                else begin
                    data_errs++;
                    $display("FAILED bus_read_data at %h type %0d: expected %h, got %h",
                             addr, code, expected, bus_read_data);
                end
        end
    endtask

    task automatic wait_irq(input logic level);
        int n;
        n = 0;
        while (key_irq !== level && n < TIMEOUT) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (key_irq !== level) begin
            timeouts++;
            $display("key_irq never reached %0d", level);
        end
    endtask

    // mixed stores, then every aligned load type at every offset
    task automatic sweep_region(input logic [63:0] base);
        bus_store(base, LS_LD, 64'hf1e2_d3c4_b5a6_9788);
        bus_store(base + 8, LS_LW, 64'h1234_5678_8bad_f00d);
        bus_store(base + 12, LS_LH, 64'haaaa_aaaa_aaaa_fe01);
        bus_store(base + 14, LS_LB, 64'h0000_0000_0000_0080);
        bus_store(base + 15, LS_LB, 64'h5555_5555_5555_557f);
        for (int off = 0; off < 16; off++) begin
            for (int code = 0; code < 7; code++) begin
                if (off % (1 << code[1:0]) == 0)
                    bus_load(base + 64'(off), 3'(code), predict_load(base + 64'(off), 3'(code)));
            end
        end
    endtask

    task automatic key_sequence();
        @(negedge CLOCK_50);
        key_code   = 8'h1c;
        key_strobe = 1'b1;
        @(negedge CLOCK_50);
        key_strobe = 1'b0;
        wait_irq(1'b1);
        bus_load(KEY_ADDR, LS_LD, 64'h1c);
        @(negedge CLOCK_50);
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
        wait_irq(1'b0);
        key_code   = 8'h00;         // zero code, no interrupt expected
        key_strobe = 1'b1;
        @(negedge CLOCK_50);
        key_strobe = 1'b0;
        repeat (3) @(negedge CLOCK_50);
        assert (key_irq === 1'b0)
            else begin
                proto_errs++;
                $display("FAILED key_irq: expected %h, got %h", 1'b0, key_irq);
            end
        bus_load(KEY_ADDR, LS_LBU, 64'h0);
    endtask

    initial begin
        data_errs        = 0;
        proto_errs       = 0;
        timeouts         = 0;
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = '0;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        key_strobe       = 1'b0;
        key_code         = 8'h00;
        irq_ack          = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
        assert (bus_read_done === 1'b1 && bus_write_done === 1'b1 && key_irq === 1'b0)
            else begin
                proto_errs++;
                $display("done flags or key_irq wrong after reset");
            end

        bus_store(64'h0000_0000_2000_0000, LS_LD, 64'hdead_beef_0bad_cafe);  // unmapped
        bus_load(64'h0000_0000_2000_0000, LS_LD, 64'h0);
        sweep_region(RAM_BASE + 64'h40);
        sweep_region(SDRAM_MIN + 64'h100);
        key_sequence();

        repeat (4) @(negedge CLOCK_50);
        $display("errors: data %0d, protocol %0d, timeouts %0d, sdram model %0d",
                 data_errs, proto_errs, timeouts, sdram_mem.err_count);
        if (data_errs + proto_errs + timeouts + sdram_mem.err_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- test/sdram_model.sv
`timescale 1ns/1ps

module sdram_model (
    input  logic        CLOCK_50,
    input  logic [21:0] sdram_addr,
    input  logic [15:0] sdram_wrdata,
    input  logic [1:0]  sdram_byte_en,
    input  logic        sdram_read_en,
    input  logic        sdram_write_en,
    output logic [15:0] sdram_rddata,
    output logic        sdram_req_wait
);
    localparam int DEPTH = 4096;  // halfwords kept, upper index bits wrap

    logic [15:0] mem [DEPTH];
    logic [31:0] lfsr = 32'h0915_b0fe;
    int          err_count;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        err_count = 0;
        sdram_req_wait = 1'b0;
        for (int i = 0; i < DEPTH; i++)
            mem[i] = 16'(i) ^ 16'hc3a5;
    end

    // one fresh bit per cycle decides the stall
    always @(negedge CLOCK_50) begin
        lfsr = lfsr_step(lfsr);
        sdram_req_wait <= lfsr[0];
    end

    assign sdram_rddata = mem[sdram_addr[11:0]];  // valid on the ending edge

    always @(posedge CLOCK_50) begin
        if (sdram_write_en && !sdram_req_wait) begin
            if (sdram_byte_en[0])
                mem[sdram_addr[11:0]][7:0] <= sdram_wrdata[7:0];
            if (sdram_byte_en[1])
                mem[sdram_addr[11:0]][15:8] <= sdram_wrdata[15:8];
        end
    end

    assert property (@(posedge CLOCK_50)
        (sdram_read_en || sdram_write_en) |-> sdram_byte_en != 2'b00)
        else begin
            err_count++;
            $display("sdram beat at index %h has no byte lane enabled", $sampled(sdram_addr));
        end

    // byte store carries the same byte on both lanes
    assert property (@(posedge CLOCK_50)
        sdram_write_en && sdram_byte_en != 2'b11 |-> sdram_wrdata[15:8] == sdram_wrdata[7:0])
        else begin
            err_count++;
            $display("FAILED sdram_wrdata: expected %h, got %h",
                     $sampled(sdram_byte_en[0]) ? {2{$sampled(sdram_wrdata[7:0])}}
                                                : {2{$sampled(sdram_wrdata[15:8])}},
                     $sampled(sdram_wrdata));
        end

endmodule

//--- logic/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                                CLOCK_50,
    input  logic                                KEY0,
    input  logic [access_pkg::ADDR_W-1:0]       bus_address,
    input  logic [access_pkg::DATA_W-1:0]       bus_write_data,
    input  access_pkg::ls_type_t                bus_ls_type,
    input  logic                                bus_read_enable,
    input  logic                                bus_write_enable,
    output logic [access_pkg::DATA_W-1:0]       bus_read_data,
    output logic                                bus_read_done,
    output logic                                bus_write_done,
    output logic [access_pkg::SDRAM_ADDR_W-1:0] sdram_addr,
    output logic [access_pkg::SDRAM_DATA_W-1:0] sdram_wrdata,
    output logic [1:0]                          sdram_byte_en,
    output logic                                sdram_read_en,
    output logic                                sdram_write_en,
    input  logic [access_pkg::SDRAM_DATA_W-1:0] sdram_rddata,
    input  logic                                sdram_req_wait,
    input  logic                                key_strobe,
    input  logic [7:0]                          key_code,
    output logic                                key_irq,
    input  logic                                irq_ack
);
    import access_pkg::*;

    // latched access shared by both memory targets
    logic [ADDR_W-1:0] acc_addr;
    ls_type_t          acc_type;
    logic [DATA_W-1:0] acc_wdata;
    logic              acc_write;

    // req/ack to the ram
    logic              ram_req;
    logic              ram_ack;
    logic [DATA_W-1:0] ram_rdata;

    // req/ack to the sdram bridge
    logic              sdram_req;
    logic              sdram_ack;
    logic [DATA_W-1:0] sdram_rdata;

    logic [7:0]        key_data;

    bus_sequencer #(
        .RAM_WORDS(RAM_WORDS)
    ) u_seq (.*);

    onchip_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_ram (.*);

    sdram_bridge u_bridge (.*);

    key_irq u_key (.*);

endmodule

//--- logic/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic [access_pkg::ADDR_W-1:0] bus_address,
    input  logic [access_pkg::DATA_W-1:0] bus_write_data,
    input  access_pkg::ls_type_t          bus_ls_type,
    input  logic                          bus_read_enable,
    input  logic                          bus_write_enable,
    output logic [access_pkg::DATA_W-1:0] bus_read_data,
    output logic                          bus_read_done,
    output logic                          bus_write_done,
    output logic                          ram_req,
    input  logic                          ram_ack,
    input  logic [access_pkg::DATA_W-1:0] ram_rdata,
    output logic                          sdram_req,
    input  logic                          sdram_ack,
    input  logic [access_pkg::DATA_W-1:0] sdram_rdata,
    output logic [access_pkg::ADDR_W-1:0] acc_addr,
    output access_pkg::ls_type_t          acc_type,
    output logic [access_pkg::DATA_W-1:0] acc_wdata,
    output logic                          acc_write,
    input  logic [7:0]                    key_data
);
    import access_pkg::*;
    import mem_map_pkg::*;

    localparam logic [ADDR_W-1:0] RAM_END = RAM_BASE + ADDR_W'(4 * RAM_WORDS);

    localparam logic [1:0] TGT_NONE  = 2'd0;
    localparam logic [1:0] TGT_RAM   = 2'd1;
    localparam logic [1:0] TGT_SDRAM = 2'd2;
    localparam logic [1:0] TGT_KEY   = 2'd3;

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_LOCAL   = 3'd1;  // key or unmapped, no target
    localparam logic [2:0] S_REQ     = 3'd2;
    localparam logic [2:0] S_RELEASE = 3'd3;  // wait for ack to drop
    localparam logic [2:0] S_DONE    = 3'd4;

    logic [2:0]        state;
    logic [1:0]        sel;
    logic [1:0]        target;
    logic              start;
    logic              target_ack;
    logic [DATA_W-1:0] target_rdata;
    logic [DATA_W-1:0] raw_data;
    logic [DATA_W-1:0] load_ext;
    logic              sign_ok;

    always_comb begin
        if (bus_address == KEY_ADDR)
            sel = TGT_KEY;
        else if (bus_address >= RAM_BASE && bus_address < RAM_END)
            sel = TGT_RAM;
        else if (bus_address >= SDRAM_MIN && bus_address < SDRAM_MAX)
            sel = TGT_SDRAM;
        else
            sel = TGT_NONE;
    end

    assign start        = state == S_IDLE && (bus_read_enable || bus_write_enable);
    assign target_ack   = (target == TGT_RAM) ? ram_ack : sdram_ack;
    assign target_rdata = (target == TGT_RAM) ? ram_rdata : sdram_rdata;

    // extend the right-aligned raw data
    always_comb begin
        sign_ok = !acc_type.f.is_unsigned;
        case (acc_type.code)
            LS_LB, LS_LBU: load_ext = {{56{sign_ok & raw_data[7]}}, raw_data[7:0]};
            LS_LH, LS_LHU: load_ext = {{48{sign_ok & raw_data[15]}}, raw_data[15:0]};
            LS_LW, LS_LWU: load_ext = {{32{sign_ok & raw_data[31]}}, raw_data[31:0]};
            LS_LD:         load_ext = raw_data;
            default:       load_ext = '0;
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            acc_addr  <= bus_address;
            acc_type  <= bus_ls_type;
            acc_wdata <= bus_write_data;
            raw_data  <= '0;                    // unmapped reads return zero
        end else if (state == S_REQ && target_ack) begin
            raw_data <= target_rdata;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= S_IDLE;
            target         <= TGT_NONE;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
            ram_req        <= 1'b0;
            sdram_req      <= 1'b0;
            acc_write      <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        if (bus_read_enable)
                            bus_read_done <= 1'b0;
                        if (bus_write_enable)
                            bus_write_done <= 1'b0;
                        acc_write <= bus_write_enable;
                        target    <= sel;
                        ram_req   <= sel == TGT_RAM;
                        sdram_req <= sel == TGT_SDRAM;
                        state     <= (sel == TGT_RAM || sel == TGT_SDRAM) ? S_REQ : S_LOCAL;
                    end
                end
                S_LOCAL: state <= S_DONE;
                S_REQ: begin
                    if (target_ack) begin
                        ram_req   <= 1'b0;
                        sdram_req <= 1'b0;
                        state     <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!target_ack)
                        state <= S_DONE;
                end
                S_DONE: begin
                    if (acc_write) begin
                        bus_write_done <= 1'b1;
                    end else begin
                        bus_read_done <= 1'b1;
                        bus_read_data <= (target == TGT_KEY) ? {{(DATA_W-8){1'b0}}, key_data}
                                                             : load_ext;
                    end
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // one target at a time on the req/ack side
    assert property (@(posedge CLOCK_50) disable iff (!KEY0) !(ram_req && sdram_req));

endmodule

//--- logic/sdram_bridge.sv
`timescale 1ns/1ps

module sdram_bridge (
    input  logic                                CLOCK_50,
    input  logic                                KEY0,
    input  logic                                sdram_req,
    output logic                                sdram_ack,
    input  logic [access_pkg::ADDR_W-1:0]       acc_addr,
    input  access_pkg::ls_type_t                acc_type,
    input  logic [access_pkg::DATA_W-1:0]       acc_wdata,
    input  logic                                acc_write,
    output logic [access_pkg::DATA_W-1:0]       sdram_rdata,
    output logic [access_pkg::SDRAM_ADDR_W-1:0] sdram_addr,
    output logic [access_pkg::SDRAM_DATA_W-1:0] sdram_wrdata,
    output logic [1:0]                          sdram_byte_en,
    output logic                                sdram_read_en,
    output logic                                sdram_write_en,
    input  logic [access_pkg::SDRAM_DATA_W-1:0] sdram_rddata,
    input  logic                                sdram_req_wait
);
    import access_pkg::*;
    import mem_map_pkg::*;

    logic [1:0] beat;          // halfword within the access
    logic [1:0] last_beat;
    logic       busy;
    logic       beat_done;
    logic       is_byte;

    assign is_byte   = acc_type.f.size == SZ_BYTE;
    assign busy      = sdram_read_en || sdram_write_en;
    assign beat_done = busy && !sdram_req_wait;

    always_comb begin
        case (acc_type.f.size)
            SZ_WORD:   last_beat = 2'd1;
            SZ_DOUBLE: last_beat = 2'd3;
            default:   last_beat = 2'd0;
        endcase
    end

    // lowest half first
    assign sdram_addr    = acc_addr[SDRAM_IDX_HI:SDRAM_IDX_LO] + SDRAM_ADDR_W'(beat);
    assign sdram_byte_en = !is_byte ? 2'b11 : (acc_addr[0] ? 2'b10 : 2'b01);
    assign sdram_wrdata  = is_byte ? {2{acc_wdata[7:0]}}
                                   : acc_wdata[SDRAM_DATA_W*beat +: SDRAM_DATA_W];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sdram_ack      <= 1'b0;
            sdram_read_en  <= 1'b0;
            sdram_write_en <= 1'b0;
            beat           <= 2'd0;
        end else if (!sdram_req) begin
            sdram_ack <= 1'b0;
        end else if (!sdram_ack && !busy) begin
            sdram_read_en  <= !acc_write;
            sdram_write_en <= acc_write;
            beat           <= 2'd0;
        end else if (beat_done) begin
            if (beat == last_beat) begin
                sdram_read_en  <= 1'b0;
                sdram_write_en <= 1'b0;
                sdram_ack      <= 1'b1;
            end else begin
                beat <= beat + 2'd1;            // enable stays up for the next half
            end
        end
    end

    // read halves land at their place in the word
    always_ff @(posedge CLOCK_50) begin
        if (beat_done && sdram_read_en) begin
            if (is_byte)
                sdram_rdata <= {56'd0, acc_addr[0] ? sdram_rddata[15:8] : sdram_rddata[7:0]};
            else
                sdram_rdata[SDRAM_DATA_W*beat +: SDRAM_DATA_W] <= sdram_rddata;
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(sdram_read_en && sdram_write_en));

    // a stalled beat keeps its enable and address
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        busy && sdram_req_wait |=> busy && $stable(sdram_addr));

endmodule

//--- logic/onchip_ram.sv
`timescale 1ns/1ps

module onchip_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                          CLOCK_50,
    input  logic                          KEY0,
    input  logic                          ram_req,
    output logic                          ram_ack,
    input  logic [access_pkg::ADDR_W-1:0] acc_addr,
    input  access_pkg::ls_type_t          acc_type,
    input  logic [access_pkg::DATA_W-1:0] acc_wdata,
    input  logic                          acc_write,
    output logic [access_pkg::DATA_W-1:0] ram_rdata
);
    import access_pkg::*;
    import mem_map_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0]       mem [RAM_WORDS];
    logic [ADDR_W-1:0] offset;
    logic [IDX_W-1:0]  word_idx;
    logic [3:0]        lane_en;
    logic [31:0]       wr_word;
    logic              phase;      // upper word of a doubleword
    logic              do_access;

    assign offset    = acc_addr - RAM_BASE;
    assign word_idx  = offset[IDX_W+1:2] + IDX_W'(phase);
    assign do_access = ram_req && !ram_ack;

    always_comb begin
        case (acc_type.f.size)
            SZ_BYTE: begin
                lane_en = 4'b0001 << acc_addr[1:0];
                wr_word = {4{acc_wdata[7:0]}};
            end
            SZ_HALF: begin
                lane_en = 4'b0011 << acc_addr[1:0];
                wr_word = {2{acc_wdata[15:0]}};
            end
            SZ_DOUBLE: begin
                lane_en = 4'b1111;
                wr_word = phase ? acc_wdata[63:32] : acc_wdata[31:0];
            end
            default: begin
                lane_en = 4'b1111;
                wr_word = acc_wdata[31:0];
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (do_access) begin
            if (acc_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (lane_en[b])
                        mem[word_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end else if (phase) begin
                ram_rdata[63:32] <= mem[word_idx];
            end else begin
                ram_rdata <= {32'd0, mem[word_idx]} >> (8 * acc_addr[1:0]);
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ram_ack <= 1'b0;
            phase   <= 1'b0;
        end else if (!ram_req) begin
            ram_ack <= 1'b0;
        end else if (do_access) begin
            if (acc_type.f.size == SZ_DOUBLE && !phase) begin
                phase <= 1'b1;                  // second cycle for the upper word
            end else begin
                phase   <= 1'b0;
                ram_ack <= 1'b1;
            end
        end
    end

    // sequencer only hands over naturally aligned accesses
    assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ram_req |-> (acc_addr[2:0] & 3'((4'd1 << acc_type.f.size) - 4'd1)) == 3'd0);

endmodule

//--- logic/key_irq.sv
`timescale 1ns/1ps

module key_irq (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_strobe,
    input  logic [7:0] key_code,
    input  logic       irq_ack,
    output logic       key_irq,
    output logic [7:0] key_data
);
    logic strobe_d;
    logic strobe_rise;

    assign strobe_rise = key_strobe && !strobe_d;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            strobe_d <= 1'b0;
            key_data <= 8'd0;
            key_irq  <= 1'b0;
        end else begin
            strobe_d <= key_strobe;
            if (strobe_rise)
                key_data <= key_code;
            // a new key wins over an ack in the same cycle
            if (strobe_rise && key_code != 8'd0)
                key_irq <= 1'b1;
            else if (irq_ack)
                key_irq <= 1'b0;
        end
    end

endmodule

//--- logic/mem_map_pkg.sv
package mem_map_pkg;

    // byte addresses on the CPU bus
    localparam logic [63:0] KEY_ADDR  = 64'h0000_0000_0000_0100;
    localparam logic [63:0] RAM_BASE  = 64'h0000_0000_0000_1000;

    // sdram window
    localparam logic [63:0] SDRAM_MIN = 64'h0000_0000_0080_0000;  // first byte inside
    localparam logic [63:0] SDRAM_MAX = 64'h0000_0000_0100_0000;  // first byte past the end

    // halfword index bits taken from the byte address
    localparam int SDRAM_IDX_LO = 1;
    localparam int SDRAM_IDX_HI = 22;

endpackage

//--- logic/access_pkg.sv
package access_pkg;

    localparam int ADDR_W       = 64;
    localparam int DATA_W       = 64;
    localparam int SDRAM_ADDR_W = 22;
    localparam int SDRAM_DATA_W = 16;

    // raw load/store codes, stores use the signed ones
    localparam logic [2:0] LS_LB  = 3'b000;
    localparam logic [2:0] LS_LH  = 3'b001;
    localparam logic [2:0] LS_LW  = 3'b010;
    localparam logic [2:0] LS_LD  = 3'b011;
    localparam logic [2:0] LS_LBU = 3'b100;
    localparam logic [2:0] LS_LHU = 3'b101;
    localparam logic [2:0] LS_LWU = 3'b110;

    // access size field
    localparam logic [1:0] SZ_BYTE   = 2'b00;
    localparam logic [1:0] SZ_HALF   = 2'b01;
    localparam logic [1:0] SZ_WORD   = 2'b10;
    localparam logic [1:0] SZ_DOUBLE = 2'b11;

    typedef union packed {
        logic [2:0] code;
        struct packed {
            logic       is_unsigned;  // zero extend on load
            logic [1:0] size;
        } f;
    } ls_type_t;

endpackage
